//--- Bender.yml
package:
  name: fpu_ctl

dependencies: {}

sources:
  # RTL, package first
  - files:
      - fpu_ctl_pkg.sv
      - fpu_strobe_gen.sv
      - fpu_state_seq.sv
      - fpu_pass_cnt.sv
      - fpu_ctl_decode.sv
      - fpu_ctl.sv

  # testbench
  - target: simulation
    files:
      - tb_fpu_ctl.sv

//--- compile.f
fpu_ctl_pkg.sv
fpu_strobe_gen.sv
fpu_state_seq.sv
fpu_pass_cnt.sv
fpu_ctl_decode.sv
fpu_ctl.sv
tb_fpu_ctl.sv

//--- fpu_ctl.sv
/*
	FPU control sequencer
	strobe timing, state flip-flops, pass counter and output decode
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_ctl #(
	parameter int STROBE_TICKS = 6
) (
	input  wire                       got_fp,
	input  wire                       _0_f_,
	input  wire                       efp,
	input  wire fpu_ctl_pkg::fpu_op_t op,
	input  wire                       nz,
	input  wire                       ok,
	output logic                      busy,
	output logic                      ekc,
	output logic                      clock_ta,
	output logic                      clock_tb,
	output logic                      clock_m,
	output logic                      shift_r,
	output logic                      add_en,
	output logic                      sub_en,
	output logic                      clr_t,
	output logic                      clr_zp,
	output logic                      rd_fp
);

	fpu_ctl_pkg::fpu_state_e state;
	fpu_ctl_pkg::fpu_op_t    op_q;
	fpu_ctl_pkg::pass_cnt_t  pass;
	logic                    run;
	logic                    strob1;
	logic                    strob2;
	logic                    adv;
	logic                    pass_clr;
	logic                    pass_step;
	logic                    pass_last;

	fpu_strobe_gen #(
		.STROBE_TICKS(STROBE_TICKS)
	) u_strobe (
		.got_fp(got_fp),
		._0_f_ (_0_f_),
		.run   (run),
		.strob1(strob1),
		.strob2(strob2),
		.adv   (adv)
	);

	fpu_state_seq u_seq (
		.got_fp   (got_fp),
		._0_f_    (_0_f_),
		.efp      (efp),
		.op       (op),
		.nz       (nz),
		.ok       (ok),
		.adv      (adv),
		.pass_last(pass_last),
		.state    (state),
		.op_q     (op_q),
		.run      (run),
		.busy     (busy),
		.ekc      (ekc),
		.pass_clr (pass_clr),
		.pass_step(pass_step)
	);

	fpu_pass_cnt u_pass (
		.got_fp   (got_fp),
		._0_f_    (_0_f_),
		.pass_clr (pass_clr),
		.pass_step(pass_step),
		.pass     (pass),
		.pass_last(pass_last)
	);

	fpu_ctl_decode u_decode (
		.state   (state),
		.op_q    (op_q),
		.pass    (pass),
		.strob1  (strob1),
		.strob2  (strob2),
		.clock_ta(clock_ta),
		.clock_tb(clock_tb),
		.clock_m (clock_m),
		.shift_r (shift_r),
		.add_en  (add_en),
		.sub_en  (sub_en),
		.clr_t   (clr_t),
		.clr_zp  (clr_zp),
		.rd_fp   (rd_fp)
	);

endmodule

`default_nettype wire

//--- fpu_ctl_decode.sv
/*
	FPU control decode
	datapath load, shift and clear pulses from phase, pass count and strobes
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_ctl_decode (
	input  wire fpu_ctl_pkg::fpu_state_e state,
	input  wire fpu_ctl_pkg::fpu_op_t    op_q,
	input  wire fpu_ctl_pkg::pass_cnt_t  pass,
	input  wire                          strob1,
	input  wire                          strob2,
	output logic                         clock_ta,
	output logic                         clock_tb,
	output logic                         clock_m,
	output logic                         shift_r,
	output logic                         add_en,
	output logic                         sub_en,
	output logic                         clr_t,
	output logic                         clr_zp,
	output logic                         rd_fp
);

	logic in_read;
	logic in_align;
	logic in_arith;
	logic in_loop;
	logic in_norm;
	logic in_zero;
	logic pass_odd;

	assign in_read  = (state == fpu_ctl_pkg::S_READ);
	assign in_align = (state == fpu_ctl_pkg::S_ALIGN);
	assign in_arith = (state == fpu_ctl_pkg::S_ARITH);
	assign in_loop  = (state == fpu_ctl_pkg::S_LOOP);
	assign in_norm  = (state == fpu_ctl_pkg::S_NORM);
	assign in_zero  = (state == fpu_ctl_pkg::S_ZERO);

	// lpa set
	assign pass_odd = pass[0];

	// strob1 phase loads
	assign rd_fp    = strob1 && in_read;
	assign clock_ta = strob1 && in_align;
	assign clock_tb = strob1 && in_loop;
	assign clock_m  = strob1 && in_norm;

	// add for ADD and MUL, subtract for SUB and DIV
	assign add_en = strob1 &&
		((in_arith && (op_q == fpu_ctl_pkg::OP_ADD)) ||
		 (in_loop && (op_q == fpu_ctl_pkg::OP_MUL)));
	assign sub_en = strob1 &&
		((in_arith && (op_q == fpu_ctl_pkg::OP_SUB)) ||
		 (in_loop && (op_q == fpu_ctl_pkg::OP_DIV)));

	// strob2 phase shifts and clears
	assign shift_r = strob2 && (in_align || (in_loop && pass_odd));
	assign clr_t   = strob2 && in_read;
	assign clr_zp  = strob2 && in_zero;

endmodule

`default_nettype wire

//--- fpu_ctl_pkg.sv
/*
	FPU control shared definitions
	operation codes, sequencer phases and counter widths
*/
`default_nettype none

package fpu_ctl_pkg;

	// operation code from the CPU side
	typedef logic [2:0] fpu_op_t;

	localparam fpu_op_t OP_ADD = 3'd0;
	localparam fpu_op_t OP_SUB = 3'd1;
	localparam fpu_op_t OP_MUL = 3'd2;
	localparam fpu_op_t OP_DIV = 3'd3;
	localparam fpu_op_t OP_NRM = 3'd4;

	// sequencer phase
	typedef enum logic [3:0] {
		S_IDLE  = 4'd0,
		S_READ  = 4'd1,
		S_ALIGN = 4'd2,
		S_ARITH = 4'd3,
		S_LOOP  = 4'd4,
		S_NORM  = 4'd5,
		S_ZERO  = 4'd6,
		S_END   = 4'd7
	} fpu_state_e;

	// lpa is bit 0, lpb is bit 1
	typedef logic [1:0] pass_cnt_t;

	// phase counter inside one state
	typedef logic [3:0] tick_cnt_t;

	// multiply and divide always take this many loop passes
	localparam int LOOP_PASSES = 4;

	// upper bound on normalization passes
	localparam int NORM_PASSES_MAX = 8;

endpackage

`default_nettype wire

//--- fpu_pass_cnt.sv
/*
	FPU pass counter
	lpa/lpb count of multiply and divide loop passes
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_pass_cnt (
	input  wire                    got_fp,
	input  wire                    _0_f_,
	input  wire                    pass_clr,
	input  wire                    pass_step,
	output fpu_ctl_pkg::pass_cnt_t pass,
	output logic                   pass_last
);

	localparam fpu_ctl_pkg::pass_cnt_t PASS_LAST =
		fpu_ctl_pkg::pass_cnt_t'(fpu_ctl_pkg::LOOP_PASSES - 1);

	// wraps from 3 back to 0 on the final step
	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			pass <= '0;
		end else if (pass_clr) begin
			pass <= '0;
		end else if (pass_step) begin
			pass <= pass + fpu_ctl_pkg::pass_cnt_t'(1);
		end
	end

	// fourth pass is running
	assign pass_last = (pass == PASS_LAST);

endmodule

`default_nettype wire

//--- fpu_state_seq.sv
/*
	FPU state sequencer
	holds the operation phase and picks the next one from op code and flags
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_state_seq (
	input  wire                     got_fp,
	input  wire                     _0_f_,
	input  wire                     efp,
	input  wire fpu_ctl_pkg::fpu_op_t op,
	input  wire                     nz,
	input  wire                     ok,
	input  wire                     adv,
	input  wire                     pass_last,
	output fpu_ctl_pkg::fpu_state_e state,
	output fpu_ctl_pkg::fpu_op_t    op_q,
	output logic                    run,
	output logic                    busy,
	output logic                    ekc,
	output logic                    pass_clr,
	output logic                    pass_step
);

	localparam int NORM_W = $clog2(fpu_ctl_pkg::NORM_PASSES_MAX);
	localparam logic [NORM_W-1:0] NORM_LAST = NORM_W'(fpu_ctl_pkg::NORM_PASSES_MAX - 1);

	fpu_ctl_pkg::fpu_state_e next_state;
	logic [NORM_W-1:0]       norm_cnt;
	logic                    norm_done;

	// stop on a normalized mantissa or after the last allowed pass
	assign norm_done = ok || (norm_cnt == NORM_LAST);

	always_comb begin
		next_state = state;
		case (state)
			fpu_ctl_pkg::S_IDLE: begin
				if (efp) begin
					next_state = fpu_ctl_pkg::S_READ;
				end
			end
			fpu_ctl_pkg::S_READ: begin
				if (!nz) begin
					next_state = fpu_ctl_pkg::S_ZERO;
				end else begin
					case (op_q)
						fpu_ctl_pkg::OP_ADD, fpu_ctl_pkg::OP_SUB: next_state = fpu_ctl_pkg::S_ALIGN;
						fpu_ctl_pkg::OP_MUL, fpu_ctl_pkg::OP_DIV: next_state = fpu_ctl_pkg::S_LOOP;
						fpu_ctl_pkg::OP_NRM: next_state = fpu_ctl_pkg::S_NORM;
						default: next_state = fpu_ctl_pkg::S_END;
					endcase
				end
			end
			fpu_ctl_pkg::S_ALIGN: next_state = fpu_ctl_pkg::S_ARITH;
			fpu_ctl_pkg::S_ARITH: next_state = fpu_ctl_pkg::S_NORM;
			fpu_ctl_pkg::S_LOOP: begin
				if (pass_last) begin
					next_state = fpu_ctl_pkg::S_NORM;
				end
			end
			fpu_ctl_pkg::S_NORM: begin
				if (norm_done) begin
					next_state = fpu_ctl_pkg::S_END;
				end
			end
			fpu_ctl_pkg::S_ZERO: next_state = fpu_ctl_pkg::S_END;
			fpu_ctl_pkg::S_END:  next_state = fpu_ctl_pkg::S_IDLE;
			default: next_state = fpu_ctl_pkg::S_IDLE;
		endcase
	end

	// start leaves idle at once, every later step waits for adv
	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			state <= fpu_ctl_pkg::S_IDLE;
		end else if (adv || (state == fpu_ctl_pkg::S_IDLE)) begin
			state <= next_state;
		end
	end

	// op code taken only from an accepted start
	always_ff @(posedge got_fp) begin
		if ((state == fpu_ctl_pkg::S_IDLE) && efp) begin
			op_q <= op;
		end
	end

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			norm_cnt <= '0;
		end else if (state != fpu_ctl_pkg::S_NORM) begin
			norm_cnt <= '0;
		end else if (adv) begin
			norm_cnt <= norm_cnt + NORM_W'(1);
		end
	end

	assign busy = (state != fpu_ctl_pkg::S_IDLE);
	assign run  = busy;
	assign ekc  = adv && (state == fpu_ctl_pkg::S_END);

	// lpa/lpb control
	assign pass_clr  = adv && (state == fpu_ctl_pkg::S_READ) && (next_state == fpu_ctl_pkg::S_LOOP);
	assign pass_step = adv && (state == fpu_ctl_pkg::S_LOOP);

endmodule

`default_nettype wire

//--- fpu_strobe_gen.sv
/*
	FPU strobe generator
	synchronous phase counter giving strob1, strob2 and the advance tick
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_strobe_gen #(
	parameter int STROBE_TICKS = 6
) (
	input  wire  got_fp,
	input  wire  _0_f_,
	input  wire  run,
	output logic strob1,
	output logic strob2,
	output logic adv
);

	localparam fpu_ctl_pkg::tick_cnt_t TICK_S1  = fpu_ctl_pkg::tick_cnt_t'(1);
	localparam fpu_ctl_pkg::tick_cnt_t TICK_S2  = fpu_ctl_pkg::tick_cnt_t'(STROBE_TICKS - 2);
	localparam fpu_ctl_pkg::tick_cnt_t TICK_ADV = fpu_ctl_pkg::tick_cnt_t'(STROBE_TICKS - 1);

	fpu_ctl_pkg::tick_cnt_t tick;

	// one pass of the counter spans one sequencer state
	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			tick <= '0;
		end else if (!run || adv) begin
			tick <= '0;
		end else begin
			tick <= tick + fpu_ctl_pkg::tick_cnt_t'(1);
		end
	end

	// register clock phase
	assign strob1 = run && (tick == TICK_S1);

	// clear and settle phase, late in the state
	assign strob2 = run && (tick == TICK_S2);

	// last tick, state flip-flops step here
	assign adv = run && (tick == TICK_ADV);

endmodule

`default_nettype wire

//--- tb_fpu_ctl.sv
/*
	FPU control sequencer testbench
	table of operations applied in a loop, pulse counts and latency checked
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_ctl;

	localparam int TICKS        = 6;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int LOOP_N       = 4;
	localparam int NORM_CAP     = 8;
	localparam int NUM_FIXED    = 12;
	localparam int NUM_RAND     = 6;
	localparam int NUM_ROWS     = NUM_FIXED + NUM_RAND;
	localparam int ROW_LIMIT    = 20 * TICKS;
	localparam int WATCHDOG_NS  = NUM_ROWS * 20 * TICKS * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

	logic                 got_fp;
	logic                 _0_f_;
	logic                 efp;
	fpu_ctl_pkg::fpu_op_t op;
	logic                 nz;
	logic                 ok;
	logic                 busy;
	logic                 ekc;
	logic                 clock_ta;
	logic                 clock_tb;
	logic                 clock_m;
	logic                 shift_r;
	logic                 add_en;
	logic                 sub_en;
	logic                 clr_t;
	logic                 clr_zp;
	logic                 rd_fp;

	// op, nz, S_NORM passes with ok low, cycle of a stray efp (0 for none)
	fpu_ctl_pkg::fpu_op_t row_op [NUM_ROWS];
	logic                 row_nz [NUM_ROWS];
	int                   row_norm_low [NUM_ROWS];
	int                   row_stray [NUM_ROWS];

	integer seed = 32'hb752;
	int     errors = 0;

	fpu_ctl #(
		.STROBE_TICKS(TICKS)
	) DUT (
		.got_fp  (got_fp),
		._0_f_   (_0_f_),
		.efp     (efp),
		.op      (op),
		.nz      (nz),
		.ok      (ok),
		.busy    (busy),
		.ekc     (ekc),
		.clock_ta(clock_ta),
		.clock_tb(clock_tb),
		.clock_m (clock_m),
		.shift_r (shift_r),
		.add_en  (add_en),
		.sub_en  (sub_en),
		.clr_t   (clr_t),
		.clr_zp  (clr_zp),
		.rd_fp   (rd_fp)
	);

	initial begin
		got_fp = 1'b0;
		forever #(CLK_PERIOD / 2) got_fp = ~got_fp;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic set_row(input int r, input fpu_ctl_pkg::fpu_op_t o, input logic z,
		input int low, input int stray);
		row_op[r]       = o;
		row_nz[r]       = z;
		row_norm_low[r] = low;
		row_stray[r]    = stray;
	endtask

	task automatic load_table();
		set_row(0, fpu_ctl_pkg::OP_ADD, 1'b1, 0, 0);
		set_row(1, fpu_ctl_pkg::OP_SUB, 1'b1, 0, 0);
		set_row(2, fpu_ctl_pkg::OP_MUL, 1'b1, 0, 0);
		set_row(3, fpu_ctl_pkg::OP_DIV, 1'b1, 2, 0);
		set_row(4, fpu_ctl_pkg::OP_NRM, 1'b1, 3, 0);
		set_row(5, fpu_ctl_pkg::OP_NRM, 1'b1, 10, 0);
		set_row(6, fpu_ctl_pkg::OP_ADD, 1'b0, 0, 0);
		set_row(7, fpu_ctl_pkg::OP_MUL, 1'b0, 0, 0);
		set_row(8, fpu_ctl_pkg::OP_ADD, 1'b1, 7, 0);
		set_row(9, fpu_ctl_pkg::OP_DIV, 1'b1, 0, 9);
		set_row(10, fpu_ctl_pkg::OP_MUL, 1'b1, 1, 20);
		set_row(11, fpu_ctl_pkg::OP_SUB, 1'b1, 0, 3);
		// random pass counts that may exceed the cap
		for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
			set_row(r, fpu_ctl_pkg::fpu_op_t'(r % 5), 1'b1, {$random(seed)} % 10, 0);
		end
	endtask

	// nothing may move while idle
	task automatic check_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge got_fp);
			check_value("busy", 0, busy);
			check_value("ekc", 0, ekc);
			check_value("clock_ta", 0, clock_ta);
			check_value("clock_tb", 0, clock_tb);
			check_value("clock_m", 0, clock_m);
			check_value("shift_r", 0, shift_r);
			check_value("add_en", 0, add_en);
			check_value("sub_en", 0, sub_en);
			check_value("clr_t", 0, clr_t);
			check_value("clr_zp", 0, clr_zp);
			check_value("rd_fp", 0, rd_fp);
		end
	endtask

	task automatic apply_row(input int r);
		int   cyc;
		int   lat;
		int   k;
		int   n_states;
		int   n_busy;
		int   n_rd;
		int   n_ta;
		int   n_tb;
		int   n_m;
		int   n_sh;
		int   n_add;
		int   n_sub;
		int   n_ct;
		int   n_zp;
		logic done;
		logic is_as;
		logic is_md;
		logic is_add;
		logic is_sub;

		// expected sequence length from the operation rules
		k      = (row_norm_low[r] + 1 > NORM_CAP) ? NORM_CAP : row_norm_low[r] + 1;
		is_add = row_nz[r] &&
			(row_op[r] == fpu_ctl_pkg::OP_ADD || row_op[r] == fpu_ctl_pkg::OP_MUL);
		is_sub = row_nz[r] &&
			(row_op[r] == fpu_ctl_pkg::OP_SUB || row_op[r] == fpu_ctl_pkg::OP_DIV);
		is_as  = row_nz[r] &&
			(row_op[r] == fpu_ctl_pkg::OP_ADD || row_op[r] == fpu_ctl_pkg::OP_SUB);
		is_md  = row_nz[r] &&
			(row_op[r] == fpu_ctl_pkg::OP_MUL || row_op[r] == fpu_ctl_pkg::OP_DIV);
		if (!row_nz[r]) begin
			k        = 0;
			n_states = 3;
		end else if (is_as) begin
			n_states = 4 + k;
		end else if (is_md) begin
			n_states = 2 + LOOP_N + k;
		end else begin
			n_states = 2 + k;
		end

		n_busy = 0;
		n_rd   = 0;
		n_ta   = 0;
		n_tb   = 0;
		n_m    = 0;
		n_sh   = 0;
		n_add  = 0;
		n_sub  = 0;
		n_ct   = 0;
		n_zp   = 0;
		lat    = 0;
		done   = 1'b0;

		@(negedge got_fp);
		efp = 1'b1;
		op  = row_op[r];
		nz  = row_nz[r];
		ok  = 1'b0;
		cyc = 1;
		while (!done && cyc <= ROW_LIMIT) begin
			@(negedge got_fp);
			cyc++;
			if (busy) n_busy++;
			if (rd_fp) n_rd++;
			if (clock_ta) n_ta++;
			if (clock_tb) n_tb++;
			if (clock_m) n_m++;
			if (shift_r) n_sh++;
			if (add_en) n_add++;
			if (sub_en) n_sub++;
			if (clr_t) n_ct++;
			if (clr_zp) n_zp++;
			if (ekc) begin
				done = 1'b1;
				lat  = cyc;
			end
			// start while busy with another op code
			efp = (cyc == row_stray[r]);
			if (efp) begin
				op = fpu_ctl_pkg::OP_NRM;
			end
			// mantissa becomes normalized after the chosen number of passes
			ok = (n_m > row_norm_low[r]);
		end
		efp = 1'b0;

		if (!done) begin
			$display("row %0d: ekc did not arrive within %0d cycles", r, ROW_LIMIT);
			errors++;
		end else begin
			@(negedge got_fp);
			check_value("busy", 0, busy);
			check_value("ekc", 0, ekc);
		end

		check_value("latency", n_states * TICKS + 1, lat);
		check_value("busy", n_states * TICKS, n_busy);
		check_value("rd_fp", 1, n_rd);
		check_value("clr_t", 1, n_ct);
		check_value("clock_ta", is_as, n_ta);
		check_value("clock_tb", is_md ? LOOP_N : 0, n_tb);
		check_value("add_en", is_add ? (is_md ? LOOP_N : 1) : 0, n_add);
		check_value("sub_en", is_sub ? (is_md ? LOOP_N : 1) : 0, n_sub);
		check_value("shift_r", is_as ? 1 : (is_md ? LOOP_N / 2 : 0), n_sh);
		check_value("clock_m", k, n_m);
		check_value("clr_zp", !row_nz[r], n_zp);
	endtask

	initial begin
		_0_f_ = 1'b0;
		efp   = 1'b0;
		op    = fpu_ctl_pkg::OP_ADD;
		nz    = 1'b0;
		ok    = 1'b0;
		load_table();
		check_quiet(RESET_CYCLES);
		_0_f_ = 1'b1;
		check_quiet(10);
		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(r);
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
